/* verilog.f */
src/blk_pkg.sv
src/blk_if.sv
src/block_looper.sv
src/block_dispatch.sv
src/block_worker.sv
src/scratch_arbiter.sv
src/block_sum_top.sv
tests/block_sum_checker.sv
tests/block_sum_monitor.sv
tests/tb_block_sum.sv

/* Makefile */
# Verilator flow for the block sum engine

TOP = tb_block_sum

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --sv --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_block_sum.sv */
`timescale 1ns/100ps

module tb_block_sum;
	import blk_pkg::*;

	localparam int N_CMDS = 7;
	// Full 15x15 sweep is the longest command
	localparam int ACK_TIMEOUT = 6000;

	// One table row per command
	typedef struct packed {
		logic [GRID_BW-1:0] step_row;
		logic [GRID_BW-1:0] step_col;
		logic [GRID_BW-1:0] end_row;
		logic [GRID_BW-1:0] end_col;
		logic [15:0] blocks;
		logic reload;
	} cmd_t;

	logic i_clk;
	logic i_rst;
	logic i_src_rdy;
	logic o_src_ack;
	logic [GRID_BW-1:0] i_step_row;
	logic [GRID_BW-1:0] i_step_col;
	logic [GRID_BW-1:0] i_end_row;
	logic [GRID_BW-1:0] i_end_col;
	logic i_mem_we;
	logic [ADDR_BW-1:0] i_mem_addr;
	logic [DATA_BW-1:0] i_mem_wdata;
	logic o_res_dval;
	logic [GRID_BW-1:0] o_res_row;
	logic [GRID_BW-1:0] o_res_col;
	logic [SUM_BW-1:0] o_res_sum;

	// Copy of what the memory holds
	logic [DATA_BW-1:0] shadow [MEM_WORDS];
	cmd_t cmds [N_CMDS];
	int exp_blocks;
	int seed;
	bit timed_out;
	int sum_errs;
	int count_errs;
	int missing;
	int dups;
	int extras;
	int assert_errs;
	int total;

	block_sum_top dut0(
		.i_clk(i_clk), .i_rst(i_rst),
		.i_src_rdy(i_src_rdy), .o_src_ack(o_src_ack),
		.i_step_row(i_step_row), .i_step_col(i_step_col),
		.i_end_row(i_end_row), .i_end_col(i_end_col),
		.i_mem_we(i_mem_we), .i_mem_addr(i_mem_addr), .i_mem_wdata(i_mem_wdata),
		.o_res_dval(o_res_dval), .o_res_row(o_res_row),
		.o_res_col(o_res_col), .o_res_sum(o_res_sum)
	);

	block_sum_monitor u_monitor(
		.i_clk(i_clk), .i_rst(i_rst),
		.i_src_rdy(i_src_rdy), .i_src_ack(o_src_ack),
		.i_step_row(i_step_row), .i_step_col(i_step_col),
		.i_end_row(i_end_row), .i_end_col(i_end_col),
		.i_exp_blocks(exp_blocks), .i_shadow(shadow),
		.i_res_dval(o_res_dval), .i_res_row(o_res_row),
		.i_res_col(o_res_col), .i_res_sum(o_res_sum),
		.o_sum_errs(sum_errs), .o_count_errs(count_errs),
		.o_missing(missing), .o_dups(dups), .o_extras(extras)
	);

	always #5 i_clk = ~i_clk;

	// ============================================================
	// Stimulus tasks
	// ============================================================

	// Fill every word with a random byte, one write per cycle
	task automatic load_memory();
		logic [DATA_BW-1:0] val;
		for (int a = 0; a < MEM_WORDS; a++) begin
			@(posedge i_clk);
			val = DATA_BW'($random(seed));
			shadow[a] = val;
			i_mem_we <= 1'b1;
			i_mem_addr <= ADDR_BW'(a);
			i_mem_wdata <= val;
		end
		@(posedge i_clk);
		i_mem_we <= 1'b0;
	endtask

	// Present one table row and hold it until o_src_ack
	task automatic run_command(input int n);
		int cycles;
		@(posedge i_clk);
		i_step_row <= cmds[n].step_row;
		i_step_col <= cmds[n].step_col;
		i_end_row <= cmds[n].end_row;
		i_end_col <= cmds[n].end_col;
		exp_blocks <= int'(cmds[n].blocks);
		i_src_rdy <= 1'b1;
		cycles = 0;
		do begin
			@(posedge i_clk);
			cycles++;
		end while (!o_src_ack && cycles < ACK_TIMEOUT);
		if (!o_src_ack) begin
			timed_out = 1'b1;
			$display("Command %0d got no acknowledge within %0d cycles", n, ACK_TIMEOUT);
		end
		i_src_rdy <= 1'b0;
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		i_clk = 1'b0;
		i_rst = 1'b1;
		i_src_rdy = 1'b0;
		i_step_row = 4'd1;
		i_step_col = 4'd1;
		i_end_row = '0;
		i_end_col = '0;
		i_mem_we = 1'b0;
		i_mem_addr = '0;
		i_mem_wdata = '0;
		exp_blocks = 0;
		timed_out = 1'b0;
		seed = 32'hf0cd4c7a;
		// Steps row/col, ends row/col, block count, reload first
		cmds[0] = '{4'd1, 4'd1, 4'd4, 4'd4, 16'd16, 1'b0};
		cmds[1] = '{4'd3, 4'd4, 4'd10, 4'd13, 16'd16, 1'b0};
		// Column 13 reads into the next memory row
		cmds[2] = '{4'd7, 4'd13, 4'd15, 4'd15, 16'd6, 1'b0};
		cmds[3] = '{4'd1, 4'd1, 4'd15, 4'd15, 16'd225, 1'b0};
		cmds[4] = '{4'd2, 4'd3, 4'd0, 4'd9, 16'd0, 1'b0};
		cmds[5] = '{4'd1, 4'd2, 4'd5, 4'd0, 16'd0, 1'b0};
		cmds[6] = '{4'd1, 4'd1, 4'd4, 4'd4, 16'd16, 1'b1};
		repeat (4) @(posedge i_clk);
		i_rst <= 1'b0;
		load_memory();
		for (int n = 0; n < N_CMDS && !timed_out; n++) begin
			if (cmds[n].reload) begin
				load_memory();
			end
			run_command(n);
		end
		repeat (4) @(posedge i_clk);
		assert_errs = dut0.u_looper.u_checker.fail_cnt;
		total = sum_errs + count_errs + missing + dups + extras + assert_errs + int'(timed_out);
		$display("Errors: sum %0d, count %0d, missing %0d, duplicate %0d, extra %0d, %s %0d, %s %0d",
			sum_errs, count_errs, missing, dups, extras,
			"assertion", assert_errs, "timeout", int'(timed_out));
		if (total == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* tests/block_sum_monitor.sv */
`timescale 1ns/100ps

module block_sum_monitor(
	input logic i_clk,
	input logic i_rst,
	input logic i_src_rdy,
	input logic i_src_ack,
	input logic [blk_pkg::GRID_BW-1:0] i_step_row,
	input logic [blk_pkg::GRID_BW-1:0] i_step_col,
	input logic [blk_pkg::GRID_BW-1:0] i_end_row,
	input logic [blk_pkg::GRID_BW-1:0] i_end_col,
	input int i_exp_blocks,
	input logic [blk_pkg::DATA_BW-1:0] i_shadow [blk_pkg::MEM_WORDS],
	input logic i_res_dval,
	input logic [blk_pkg::GRID_BW-1:0] i_res_row,
	input logic [blk_pkg::GRID_BW-1:0] i_res_col,
	input logic [blk_pkg::SUM_BW-1:0] i_res_sum,
	output int o_sum_errs,
	output int o_count_errs,
	output int o_missing,
	output int o_dups,
	output int o_extras
);
	import blk_pkg::*;

	// One flag per possible origin, indexed by {row, col}
	bit seen [MEM_WORDS];
	int n_res;
	// Cycles the command rdy has waited so far
	int wait_cnt;

	// ============================================================
	// Reference model
	// ============================================================

	// Origins are multiples of the step below the end
	function automatic bit in_grid(input int r, input int c);
		return r < int'(i_end_row) && c < int'(i_end_col) &&
			r % int'(i_step_row) == 0 && c % int'(i_step_col) == 0;
	endfunction

	// Words at row*16+col+k, address taken modulo 256
	function automatic logic [SUM_BW-1:0] block_sum(input int r, input int c);
		logic [SUM_BW-1:0] s;
		s = '0;
		for (int k = 0; k < BLK_W; k++) begin
			s = s + SUM_BW'(i_shadow[ADDR_BW'(r * MEM_COLS + c + k)]);
		end
		return s;
	endfunction

	// Every grid origin reported once, count and latency as listed
	task automatic close_command();
		for (int r = 0; r < MEM_COLS; r++) begin
			for (int c = 0; c < MEM_COLS; c++) begin
				if (in_grid(r, c) && !seen[ADDR_BW'(r * MEM_COLS + c)]) begin
					o_missing++;
					$display("Block at row %0d col %0d was never reported", r, c);
				end
				seen[ADDR_BW'(r * MEM_COLS + c)] = 1'b0;
			end
		end
		if (n_res != i_exp_blocks) begin
			o_count_errs++;
			$display("ERROR t=%0t result count: got %0d expected %0d",
				$time, n_res, i_exp_blocks);
		end
		// Empty grid acks a fixed 2 cycles after rdy
		if (i_exp_blocks == 0 && wait_cnt != 2) begin
			o_count_errs++;
			$display("ERROR t=%0t o_src_ack latency: got %0d expected 2", $time, wait_cnt);
		end
		n_res = 0;
		wait_cnt = 0;
	endtask

	// ============================================================
	// Watch the result strobe and the command ack
	// ============================================================

	always @(posedge i_clk) begin
		if (i_rst) begin
			foreach (seen[a]) seen[a] = 1'b0;
			n_res = 0;
			wait_cnt = 0;
			o_sum_errs = 0;
			o_count_errs = 0;
			o_missing = 0;
			o_dups = 0;
			o_extras = 0;
		end else begin
			// Command ack trails the final result by at least a cycle
			if (i_src_ack && i_res_dval) begin
				o_count_errs++;
				$display("Command was acknowledged in the same cycle as a result");
			end
			if (i_res_dval) begin
				if (!in_grid(int'(i_res_row), int'(i_res_col))) begin
					o_extras++;
					$display("Block at row %0d col %0d lies outside the grid",
						i_res_row, i_res_col);
				end else if (seen[{i_res_row, i_res_col}]) begin
					o_dups++;
					$display("Block at row %0d col %0d was reported twice",
						i_res_row, i_res_col);
				end else begin
					seen[{i_res_row, i_res_col}] = 1'b1;
					n_res++;
					if (i_res_sum !== block_sum(int'(i_res_row), int'(i_res_col))) begin
						o_sum_errs++;
						$display("ERROR t=%0t o_res_sum row %0d col %0d: got %0d expected %0d",
							$time, i_res_row, i_res_col, i_res_sum,
							block_sum(int'(i_res_row), int'(i_res_col)));
					end
				end
			end
			if (i_src_ack) begin
				close_command();
			end else if (i_src_rdy) begin
				wait_cnt++;
			end
		end
	end

endmodule

/* tests/block_sum_checker.sv */
`timescale 1ns/100ps

module block_sum_checker(
	input logic i_clk,
	input logic i_rst,
	input logic i_busy,
	input logic [blk_pkg::PEND_BW-1:0] i_pend_cnt,
	input logic i_rdy,
	input logic i_ack,
	input logic [blk_pkg::GRID_BW-1:0] i_row,
	input logic [blk_pkg::GRID_BW-1:0] i_col,
	input logic [blk_pkg::GRID_BW-1:0] i_step_row,
	input logic [blk_pkg::GRID_BW-1:0] i_step_col
);
	import blk_pkg::*;

	// Failed assertions so far, read by the testbench top
	int fail_cnt = 0;

	// Semaphore never goes past its limit
	assert property (@(posedge i_clk) disable iff (i_rst)
		i_pend_cnt <= PEND_BW'(MAX_PENDING))
		else begin
			fail_cnt++;
			$error("pending block count is above its limit");
		end

	// An offered origin stays offered and unchanged until it is taken
	assert property (@(posedge i_clk) disable iff (i_rst)
		i_rdy && !i_ack |=> i_rdy && $stable(i_row) && $stable(i_col))
		else begin
			fail_cnt++;
			$error("origin dropped or changed while waiting for ack");
		end

	// Zero stride is illegal during a command
	assert property (@(posedge i_clk) disable iff (i_rst)
		i_busy |-> i_step_row != '0 && i_step_col != '0)
		else begin
			fail_cnt++;
			$error("step of zero seen during a command");
		end

endmodule

bind block_looper block_sum_checker u_checker(
	.i_clk(i_clk), .i_rst(i_rst),
	.i_busy(busy), .i_pend_cnt(pend_cnt),
	.i_rdy(ofs.rdy), .i_ack(ofs.ack),
	.i_row(ofs.row), .i_col(ofs.col),
	.i_step_row(i_step_row), .i_step_col(i_step_col)
);

/* src/block_sum_top.sv */
`timescale 1ns/100ps

module block_sum_top(
	input logic i_clk,
	input logic i_rst,
	// Command
	input logic i_src_rdy,
	output logic o_src_ack,
	input logic [blk_pkg::GRID_BW-1:0] i_step_row,
	input logic [blk_pkg::GRID_BW-1:0] i_step_col,
	input logic [blk_pkg::GRID_BW-1:0] i_end_row,
	input logic [blk_pkg::GRID_BW-1:0] i_end_col,
	// Memory preload
	input logic i_mem_we,
	input logic [blk_pkg::ADDR_BW-1:0] i_mem_addr,
	input logic [blk_pkg::DATA_BW-1:0] i_mem_wdata,
	// Block results
	output logic o_res_dval,
	output logic [blk_pkg::GRID_BW-1:0] o_res_row,
	output logic [blk_pkg::GRID_BW-1:0] o_res_col,
	output logic [blk_pkg::SUM_BW-1:0] o_res_sum
);

	// ============================================================
	// Channels
	// ============================================================

	ofs_if lp_ofs();
	ofs_if w0_ofs();
	ofs_if w1_ofs();
	mem_if w0_mem();
	mem_if w1_mem();
	logic blk_done;

	// ============================================================
	// Instances
	// ============================================================

	block_looper u_looper(
		.i_clk(i_clk), .i_rst(i_rst),
		.i_src_rdy(i_src_rdy), .o_src_ack(o_src_ack),
		.i_step_row(i_step_row), .i_step_col(i_step_col),
		.i_end_row(i_end_row), .i_end_col(i_end_col),
		.ofs(lp_ofs.src), .i_blk_done(blk_done)
	);

	block_dispatch u_dispatch(
		.i_clk(i_clk), .i_rst(i_rst),
		.in_ofs(lp_ofs.dst), .w0_ofs(w0_ofs.src), .w1_ofs(w1_ofs.src)
	);

	block_worker u_worker0(.i_clk(i_clk), .i_rst(i_rst), .ofs(w0_ofs.dst), .mem(w0_mem.client));
	block_worker u_worker1(.i_clk(i_clk), .i_rst(i_rst), .ofs(w1_ofs.dst), .mem(w1_mem.client));

	scratch_arbiter u_arbiter(
		.i_clk(i_clk), .i_rst(i_rst),
		.i_mem_we(i_mem_we), .i_mem_addr(i_mem_addr), .i_mem_wdata(i_mem_wdata),
		.m0(w0_mem.server), .m1(w1_mem.server),
		.o_blk_done(blk_done),
		.o_res_dval(o_res_dval), .o_res_row(o_res_row),
		.o_res_col(o_res_col), .o_res_sum(o_res_sum)
	);

endmodule

/* src/scratch_arbiter.sv */
`timescale 1ns/100ps

module scratch_arbiter(
	input logic i_clk,
	input logic i_rst,
	input logic i_mem_we,
	input blk_pkg::blk_addr_u i_mem_addr,
	input logic [blk_pkg::DATA_BW-1:0] i_mem_wdata,
	mem_if.server m0,
	mem_if.server m1,
	output logic o_blk_done,
	output logic o_res_dval,
	output logic [blk_pkg::GRID_BW-1:0] o_res_row,
	output logic [blk_pkg::GRID_BW-1:0] o_res_col,
	output logic [blk_pkg::SUM_BW-1:0] o_res_sum
);
	import blk_pkg::*;

	// ============================================================
	// Internal
	// ============================================================

	logic [DATA_BW-1:0] mem [MEM_WORDS];
	logic [DATA_BW-1:0] rd_data;
	// Memory held by one worker for its whole burst
	logic lock;
	// Current holder, or the last one served while unlocked
	logic owner;
	logic [N_WORKERS-1:0] req_vec;
	logic pick;
	logic cur_dval;
	logic release_now;
	blk_addr_u sel_addr;

	assign req_vec = {m1.req, m0.req};
	// On a tie the worker not served last wins
	assign pick = (&req_vec) ? ~owner : req_vec[1];

	assign m0.gnt = lock && !owner;
	assign m1.gnt = lock && owner;
	assign m0.rdata = rd_data;
	assign m1.rdata = rd_data;

	// Granted worker's result goes straight out
	assign cur_dval = owner ? m1.res_dval : m0.res_dval;
	assign release_now = lock && cur_dval;
	assign o_res_dval = release_now;
	assign o_res_row = owner ? m1.res_row : m0.res_row;
	assign o_res_col = owner ? m1.res_col : m0.res_col;
	assign o_res_sum = owner ? m1.res_sum : m0.res_sum;
	assign o_blk_done = release_now;

	// ============================================================
	// Scratch memory
	// ============================================================

	assign sel_addr = owner ? m1.addr : m0.addr;

	always_ff @(posedge i_clk) begin
		if (i_mem_we) begin
			mem[i_mem_addr.flat] <= i_mem_wdata;
		end
		rd_data <= mem[sel_addr.flat];
	end

	// ============================================================
	// Lock and grant
	// ============================================================

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			lock <= 1'b0;
			owner <= 1'b1;
		end else if (!lock || release_now) begin
			// Releasing worker has already dropped req
			if (|req_vec) begin
				lock <= 1'b1;
				owner <= pick;
			end else begin
				lock <= 1'b0;
			end
		end
	end

endmodule

/* src/block_worker.sv */
`timescale 1ns/100ps

module block_worker(
	input logic i_clk,
	input logic i_rst,
	ofs_if.dst ofs,
	mem_if.client mem
);
	import blk_pkg::*;

	// ============================================================
	// Internal
	// ============================================================

	// Requesting or reading the block
	logic run;
	// Result cycle, one clock
	logic fin;
	logic idle;
	logic [GRID_BW-1:0] org_row;
	logic [GRID_BW-1:0] org_col;
	// Origin address built from the row and column view
	blk_addr_u org_addr;
	// Word index within the block, 0 to BLK_W
	logic [2:0] idx;
	// Read issued last cycle, data on rdata now
	logic rd_vld;
	logic [SUM_BW-1:0] acc;
	logic last_word;

	assign idle = !run && !fin;
	assign ofs.ack = idle;

	always_comb begin
		org_addr.rc.row = org_row;
		org_addr.rc.col = org_col;
	end

	// Linear step wraps into the next row and past the last word
	assign mem.addr = org_addr.flat + ADDR_BW'(idx);
	assign mem.req = run;

	// Last word of the block is returning
	assign last_word = rd_vld && idx == 3'(BLK_W);

	// Result strobe with the origin it belongs to
	assign mem.res_dval = fin;
	assign mem.res_row = org_row;
	assign mem.res_col = org_col;
	assign mem.res_sum = acc;

	// ============================================================
	// Sequential
	// ============================================================

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			run <= 1'b0;
			fin <= 1'b0;
			rd_vld <= 1'b0;
		end else begin
			fin <= 1'b0;
			if (idle && ofs.rdy) begin
				run <= 1'b1;
			end else if (run && last_word) begin
				run <= 1'b0;
				fin <= 1'b1;
			end
			rd_vld <= run && mem.gnt && idx < 3'(BLK_W);
		end
	end

	// Origin latch, word index and running sum
	always_ff @(posedge i_clk) begin
		if (idle && ofs.rdy) begin
			org_row <= ofs.row;
			org_col <= ofs.col;
			idx <= '0;
			acc <= '0;
		end else if (run) begin
			if (mem.gnt && idx < 3'(BLK_W)) begin
				idx <= idx + 1'b1;
			end
			if (rd_vld) begin
				acc <= acc + SUM_BW'(mem.rdata);
			end
		end
	end

endmodule

/* src/block_dispatch.sv */
`timescale 1ns/100ps

module block_dispatch(
	input logic i_clk,
	input logic i_rst,
	ofs_if.dst in_ofs,
	ofs_if.src w0_ofs,
	ofs_if.src w1_ofs
);
	import blk_pkg::*;

	// ============================================================
	// Internal
	// ============================================================

	// Worker that took the previous origin
	logic last;
	// Preferred worker for this origin
	logic pref;
	logic pref_ack;
	// Worker actually offered the origin
	logic sel;
	logic xfer;

	// ============================================================
	// Routing
	// ============================================================

	assign pref = ~last;
	// Worker ack only reflects idleness, so no loop through rdy
	assign pref_ack = pref ? w1_ofs.ack : w0_ofs.ack;
	// Fall back to the other worker when the preferred one is busy
	assign sel = pref_ack ? pref : last;

	assign w0_ofs.rdy = in_ofs.rdy && !sel;
	assign w1_ofs.rdy = in_ofs.rdy && sel;

	// Origin fields go to both, only one sees rdy
	assign w0_ofs.row = in_ofs.row;
	assign w0_ofs.col = in_ofs.col;
	assign w1_ofs.row = in_ofs.row;
	assign w1_ofs.col = in_ofs.col;

	assign in_ofs.ack = sel ? w1_ofs.ack : w0_ofs.ack;
	assign xfer = in_ofs.rdy && in_ofs.ack;

	// ============================================================
	// Round-robin bit
	// ============================================================

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			// Worker 0 is preferred first
			last <= 1'b1;
		end else if (xfer) begin
			last <= sel;
		end
	end

endmodule

/* src/block_looper.sv */
`timescale 1ns/100ps

module block_looper(
	input logic i_clk,
	input logic i_rst,
	input logic i_src_rdy,
	output logic o_src_ack,
	input logic [blk_pkg::GRID_BW-1:0] i_step_row,
	input logic [blk_pkg::GRID_BW-1:0] i_step_col,
	input logic [blk_pkg::GRID_BW-1:0] i_end_row,
	input logic [blk_pkg::GRID_BW-1:0] i_end_col,
	ofs_if.src ofs,
	input logic i_blk_done
);
	import blk_pkg::*;

	// ============================================================
	// Internal state
	// ============================================================

	// Command accepted and not yet acknowledged
	logic busy;
	// Set once the last origin has been handed out
	logic walk_done;
	logic [GRID_BW-1:0] row;
	logic [GRID_BW-1:0] col;
	// Blocks issued but not yet reported done
	logic [PEND_BW-1:0] pend_cnt;
	logic [PEND_BW-1:0] pend_nxt;
	logic pend_full;
	logic blk_issue;
	logic cmd_start;
	logic cmd_finish;
	// One extra bit so the end compare survives overflow
	logic [GRID_BW:0] col_sum;
	logic [GRID_BW:0] row_sum;
	logic col_wrap;
	logic row_wrap;

	// ============================================================
	// Combinational
	// ============================================================

	// Ignore the still-high command rdy during the ack cycle
	assign cmd_start = !busy && i_src_rdy && !o_src_ack;
	assign pend_full = pend_cnt == PEND_BW'(MAX_PENDING);
	assign ofs.rdy = busy && !walk_done && !pend_full;
	assign ofs.row = row;
	assign ofs.col = col;
	assign blk_issue = ofs.rdy && ofs.ack;

	// Semaphore update
	always_comb begin
		case ({blk_issue, i_blk_done})
			2'b10: pend_nxt = pend_cnt + 1'b1;
			2'b01: pend_nxt = pend_cnt - 1'b1;
			default: pend_nxt = pend_cnt;
		endcase
	end

	// Done when every origin is out and the semaphore drains
	assign cmd_finish = busy && walk_done && pend_nxt == '0;

	// Next origin, column fastest
	assign col_sum = {1'b0, col} + {1'b0, i_step_col};
	assign row_sum = {1'b0, row} + {1'b0, i_step_row};
	assign col_wrap = col_sum >= {1'b0, i_end_col};
	assign row_wrap = row_sum >= {1'b0, i_end_row};

	// ============================================================
	// Sequential
	// ============================================================

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			busy <= 1'b0;
			walk_done <= 1'b0;
			row <= '0;
			col <= '0;
			pend_cnt <= '0;
			o_src_ack <= 1'b0;
		end else begin
			pend_cnt <= pend_nxt;
			o_src_ack <= cmd_finish;
			if (cmd_start) begin
				busy <= 1'b1;
				row <= '0;
				col <= '0;
				// An end of zero means nothing to walk
				walk_done <= i_end_row == '0 || i_end_col == '0;
			end else if (cmd_finish) begin
				busy <= 1'b0;
			end else if (blk_issue) begin
				if (!col_wrap) begin
					col <= col_sum[GRID_BW-1:0];
				end else begin
					col <= '0;
					if (row_wrap) begin
						walk_done <= 1'b1;
					end else begin
						row <= row_sum[GRID_BW-1:0];
					end
				end
			end
		end
	end

endmodule

/* src/blk_if.sv */
`timescale 1ns/100ps

// Block origin channel with rdy/ack handshake
// Data is held stable while rdy waits for ack
interface ofs_if;
	import blk_pkg::*;

	logic rdy;
	logic ack;
	logic [GRID_BW-1:0] row;
	logic [GRID_BW-1:0] col;

	// Origin producer
	modport src(output rdy, row, col, input ack);
	// Origin consumer
	modport dst(input rdy, row, col, output ack);

endinterface

// Worker side of the scratch memory, plus the result strobe
// req is held for the whole burst and gnt stays with it
interface mem_if;
	import blk_pkg::*;

	logic req;
	logic gnt;
	blk_addr_u addr;
	// Synchronous read, data lags addr by one cycle
	logic [DATA_BW-1:0] rdata;
	logic res_dval;
	logic [GRID_BW-1:0] res_row;
	logic [GRID_BW-1:0] res_col;
	logic [SUM_BW-1:0] res_sum;

	// Worker end
	modport client(
		output req, addr, res_dval, res_row, res_col, res_sum,
		input gnt, rdata
	);
	// Arbiter end
	modport server(
		input req, addr, res_dval, res_row, res_col, res_sum,
		output gnt, rdata
	);

endinterface

/* src/blk_pkg.sv */
package blk_pkg;

	// ============================================================
	// Grid and memory geometry
	// ============================================================

	// One memory row holds MEM_COLS words
	localparam int MEM_COLS = 16;
	localparam int MEM_WORDS = 256;
	// Row and column coordinates are one nibble each
	localparam int GRID_BW = $clog2(MEM_COLS);
	localparam int ADDR_BW = $clog2(MEM_WORDS);
	localparam int DATA_BW = 8;

	// ============================================================
	// Block engine sizing
	// ============================================================

	// Words summed per block, starting at the origin
	localparam int BLK_W = 4;
	// Wide enough for BLK_W full-scale words
	localparam int SUM_BW = 10;
	// Blocks issued by the looper but not yet finished
	localparam int MAX_PENDING = 2;
	localparam int PEND_BW = $clog2(MAX_PENDING + 1);
	localparam int N_WORKERS = 2;

	// Scratch address, either a linear index or a row and column nibble
	typedef struct packed {
		logic [GRID_BW-1:0] row;
		logic [GRID_BW-1:0] col;
	} blk_rc_t;

	typedef union packed {
		logic [ADDR_BW-1:0] flat;
		blk_rc_t rc;
	} blk_addr_u;

endpackage
